/* issue_pkg.sv */
package issue_pkg;

    // ************************************************************************
    // widths
    // ************************************************************************

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    // ************************************************************************
    // pipeline records
    // ************************************************************************

    typedef struct packed {
        logic valid;
        logic rden1;
        logic rden2;
        logic [reg_addr_w-1:0] raddr1;
        logic [reg_addr_w-1:0] raddr2;
        logic [reg_addr_w-1:0] waddr;
        logic wren;
        logic load;
        logic [xlen-1:0] pc;
    } instr_t;

    // result of the execute or the memory stage.
    typedef struct packed {
        logic valid;
        logic wren;
        logic load;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0] wdata;
    } result_t;

    typedef struct packed {
        logic valid;
        logic rden1;
        logic rden2;
        logic [reg_addr_w-1:0] raddr1;
        logic [reg_addr_w-1:0] raddr2;
        logic [reg_addr_w-1:0] waddr;
        logic wren;
        logic load;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rdata1;    // final operands after forwarding.
        logic [xlen-1:0] rdata2;
    } issued_t;

    localparam instr_t init_instr = '0;
    localparam issued_t init_issued = '0;

endpackage

/* issue_read_if.sv */
`timescale 1ns/1ps

interface issue_read_if
    import issue_pkg::*;
();

    logic rden1;
    logic rden2;
    logic [reg_addr_w-1:0] raddr1;
    logic [reg_addr_w-1:0] raddr2;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;

    modport requester (output rden1, rden2, raddr1, raddr2, input rdata1, rdata2);

    modport provider (input rden1, rden2, raddr1, raddr2, output rdata1, rdata2);

    // forwarding only observes the request and the raw register data.
    modport monitor (input rden1, rden2, raddr1, raddr2, rdata1, rdata2);

endinterface

/* register_file.sv */
`timescale 1ns/1ps

module register_file
    import issue_pkg::*;
#(
    parameter int reg_count = 32
) (
    input logic clock,
    issue_read_if.provider read0,
    issue_read_if.provider read1,
    input result_t mem0,
    input result_t mem1
);

    localparam int idx_w = $clog2(reg_count);

    logic [xlen-1:0] regs [reg_count];

    logic wr0;
    logic wr1;

    function automatic logic [xlen-1:0] read_port(
        input logic en,
        input logic [reg_addr_w-1:0] addr
    );
        logic [idx_w-1:0] idx;
        idx = addr[idx_w-1:0];
        if (en && idx != '0) begin
            return regs[idx];
        end
        return '0;  // register zero and disabled reads give zero.
    endfunction

    always_comb begin
        read0.rdata1 = read_port(read0.rden1, read0.raddr1);
        read0.rdata2 = read_port(read0.rden2, read0.raddr2);
        read1.rdata1 = read_port(read1.rden1, read1.raddr1);
        read1.rdata2 = read_port(read1.rden2, read1.raddr2);
    end

    assign wr0 = mem0.valid && mem0.wren && mem0.waddr != '0;
    assign wr1 = mem1.valid && mem1.wren && mem1.waddr != '0;

    // mem1 is younger, so its write comes last and wins on a shared address.
    always_ff @(posedge clock) begin
        if (wr0) begin
            regs[mem0.waddr[idx_w-1:0]] <= mem0.wdata;
        end
        if (wr1) begin
            regs[mem1.waddr[idx_w-1:0]] <= mem1.wdata;
        end
    end

endmodule

/* operand_forward.sv */
`timescale 1ns/1ps

module operand_forward
    import issue_pkg::*;
(
    issue_read_if.monitor read,
    input result_t ex0,
    input result_t ex1,
    input result_t mem0,
    input result_t mem1,
    output logic [xlen-1:0] opnd1,
    output logic [xlen-1:0] opnd2
);

    function automatic logic hit(input result_t res, input logic [reg_addr_w-1:0] addr);
        return res.valid && res.wren && res.waddr != '0 && res.waddr == addr;
    endfunction

    function automatic logic [xlen-1:0] select(
        input logic en,
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0] raw
    );
        if (!en) begin
            return raw;
        end
        // youngest first; an execute load has no data yet.
        if (hit(ex1, addr) && !ex1.load) begin
            return ex1.wdata;
        end else if (hit(ex0, addr) && !ex0.load) begin
            return ex0.wdata;
        end else if (hit(mem1, addr)) begin
            return mem1.wdata;
        end else if (hit(mem0, addr)) begin
            return mem0.wdata;
        end
        return raw;
    endfunction

    assign opnd1 = select(read.rden1, read.raddr1, read.rdata1);
    assign opnd2 = select(read.rden2, read.raddr2, read.rdata2);

endmodule

/* load_use_detect.sv */
`timescale 1ns/1ps

module load_use_detect
    import issue_pkg::*;
(
    input instr_t instr0,
    input instr_t instr1,
    input result_t ex0,
    input result_t ex1,
    output logic load_stall
);

    function automatic logic uses(input instr_t instr, input result_t res);
        logic src1;
        logic src2;
        src1 = instr.rden1 && instr.raddr1 == res.waddr;
        src2 = instr.rden2 && instr.raddr2 == res.waddr;
        return instr.valid && res.valid && res.load && res.waddr != '0 && (src1 || src2);
    endfunction

    // any slot reading any execute load holds back the whole pair.
    assign load_stall = uses(instr0, ex0) || uses(instr0, ex1) ||
                        uses(instr1, ex0) || uses(instr1, ex1);

endmodule

/* issue_control.sv */
`timescale 1ns/1ps

module issue_control
    import issue_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic clear,
    input logic hold,
    input instr_t instr0,
    input instr_t instr1,
    issue_read_if.requester read0,
    issue_read_if.requester read1,
    input logic [xlen-1:0] opnd0_1,
    input logic [xlen-1:0] opnd0_2,
    input logic [xlen-1:0] opnd1_1,
    input logic [xlen-1:0] opnd1_2,
    input logic load_stall,
    output issued_t issued0,
    output issued_t issued1,
    output logic issue_stall
);

    issued_t r0;
    issued_t r1;
    issued_t next0;
    issued_t next1;

    function automatic issued_t make_issued(
        input instr_t instr,
        input logic [xlen-1:0] data1,
        input logic [xlen-1:0] data2
    );
        issued_t s;
        s.valid = instr.valid;
        s.rden1 = instr.rden1;
        s.rden2 = instr.rden2;
        s.raddr1 = instr.raddr1;
        s.raddr2 = instr.raddr2;
        s.waddr = instr.waddr;
        s.wren = instr.wren;
        s.load = instr.load;
        s.pc = instr.pc;
        s.rdata1 = data1;
        s.rdata2 = data2;
        return s;
    endfunction

    // ************************************************************************
    // source requests
    // ************************************************************************

    always_comb begin
        read0.rden1 = instr0.valid & instr0.rden1;
        read0.rden2 = instr0.valid & instr0.rden2;
        read0.raddr1 = instr0.raddr1;
        read0.raddr2 = instr0.raddr2;
        read1.rden1 = instr1.valid & instr1.rden1;
        read1.rden2 = instr1.valid & instr1.rden2;
        read1.raddr1 = instr1.raddr1;
        read1.raddr2 = instr1.raddr2;
    end

    // ************************************************************************
    // stage register
    // ************************************************************************

    always_comb begin
        next0 = make_issued(instr0, opnd0_1, opnd0_2);
        next1 = make_issued(instr1, opnd1_1, opnd1_2);
        if (load_stall) begin
            next0 = init_issued;  // upstream presents the same pair again.
            next1 = init_issued;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            r0 <= init_issued;
            r1 <= init_issued;
        end else if (clear) begin
            r0 <= init_issued;
            r1 <= init_issued;
        end else if (!hold) begin
            r0 <= next0;
            r1 <= next1;
        end
    end

    assign issued0 = r0;
    assign issued1 = r1;
    assign issue_stall = load_stall;

endmodule

/* issue_top.sv */
`timescale 1ns/1ps

module issue_top
    import issue_pkg::*;
#(
    parameter int reg_count = 32
) (
    input logic clock,
    input logic reset,
    input logic clear,
    input logic hold,
    input instr_t instr0,
    input instr_t instr1,
    input result_t ex0,
    input result_t ex1,
    input result_t mem0,
    input result_t mem1,
    output issued_t issued0,
    output issued_t issued1,
    output logic issue_stall
);

    issue_read_if read0_if ();
    issue_read_if read1_if ();

    logic [xlen-1:0] opnd0_1;
    logic [xlen-1:0] opnd0_2;
    logic [xlen-1:0] opnd1_1;
    logic [xlen-1:0] opnd1_2;
    logic load_stall;

    issue_control i_issue_control (
        .clock(clock),
        .reset(reset),
        .clear(clear),
        .hold(hold),
        .instr0(instr0),
        .instr1(instr1),
        .read0(read0_if),
        .read1(read1_if),
        .opnd0_1(opnd0_1),
        .opnd0_2(opnd0_2),
        .opnd1_1(opnd1_1),
        .opnd1_2(opnd1_2),
        .load_stall(load_stall),
        .issued0(issued0),
        .issued1(issued1),
        .issue_stall(issue_stall)
    );

    register_file #(
        .reg_count(reg_count)
    ) i_register_file (
        .clock(clock),
        .read0(read0_if),
        .read1(read1_if),
        .mem0(mem0),
        .mem1(mem1)
    );

    operand_forward i_forward0 (
        .read(read0_if),
        .ex0(ex0),
        .ex1(ex1),
        .mem0(mem0),
        .mem1(mem1),
        .opnd1(opnd0_1),
        .opnd2(opnd0_2)
    );

    operand_forward i_forward1 (
        .read(read1_if),
        .ex0(ex0),
        .ex1(ex1),
        .mem0(mem0),
        .mem1(mem1),
        .opnd1(opnd1_1),
        .opnd2(opnd1_2)
    );

    load_use_detect i_load_use_detect (
        .instr0(instr0),
        .instr1(instr1),
        .ex0(ex0),
        .ex1(ex1),
        .load_stall(load_stall)
    );

endmodule

/* issue_top_chk.sv */
`timescale 1ns/1ps

module issue_top_chk
    import issue_pkg::*;
(
    input logic clock,
    input logic reset,
    input logic clear,
    input logic hold,
    input instr_t instr0,
    input result_t ex1,
    input issued_t issued0,
    input issued_t issued1,
    input logic issue_stall
);

    int fail_count = 0;

    logic ex1_hit;

    assign ex1_hit = instr0.valid && instr0.rden1 && ex1.valid && ex1.wren && !ex1.load &&
                     ex1.waddr != '0 && ex1.waddr == instr0.raddr1;

    reset_idle: assert property (@(posedge clock)
        !reset |=> !issued0.valid && !issued1.valid && !issue_stall)
        else begin
            $error("issue stage not idle in the cycle after reset");
            fail_count = fail_count + 1;
        end

    ex1_forward: assert property (@(posedge clock) disable iff (!reset)
        ex1_hit && !issue_stall && !hold && !clear |=> issued0.rdata1 == $past(ex1.wdata))
        else begin
            $error("slot 0 operand 1 does not carry the ex1 result");
            fail_count = fail_count + 1;
        end

    stall_bubble: assert property (@(posedge clock) disable iff (!reset)
        issue_stall && !hold |=> !issued0.valid && !issued1.valid)
        else begin
            $error("load-use stall did not insert a bubble in both slots");
            fail_count = fail_count + 1;
        end

    hold_keeps: assert property (@(posedge clock) disable iff (!reset)
        hold && !clear |=> issued0 == $past(issued0) && issued1 == $past(issued1))
        else begin
            $error("stage register changed while hold was high");
            fail_count = fail_count + 1;
        end

    clear_flush: assert property (@(posedge clock) disable iff (!reset)
        clear |=> !issued0.valid && !issued1.valid)
        else begin
            $error("clear did not flush both slots");
            fail_count = fail_count + 1;
        end

endmodule

/* tb_issue_top.sv */
`timescale 1ns/1ps

module tb_issue_top
    import issue_pkg::*;
();

    logic clock = 1'b0;
    logic reset;
    logic clear;
    logic hold;
    instr_t instr0;
    instr_t instr1;
    result_t ex0;
    result_t ex1;
    result_t mem0;
    result_t mem1;
    issued_t issued0;
    issued_t issued1;
    logic issue_stall;

    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int test_start = 0;
    string test_name;

    issue_top #(
        .reg_count(32)
    ) i_issue_top (
        .clock(clock),
        .reset(reset),
        .clear(clear),
        .hold(hold),
        .instr0(instr0),
        .instr1(instr1),
        .ex0(ex0),
        .ex1(ex1),
        .mem0(mem0),
        .mem1(mem1),
        .issued0(issued0),
        .issued1(issued1),
        .issue_stall(issue_stall)
    );

    bind issue_top issue_top_chk i_chk (
        .clock(clock),
        .reset(reset),
        .clear(clear),
        .hold(hold),
        .instr0(instr0),
        .ex1(ex1),
        .issued0(issued0),
        .issued1(issued1),
        .issue_stall(issue_stall)
    );

    always #20 clock = ~clock;

    initial begin
        #400000;
        $display("watchdog expired, the run did not reach its end in time");
        $display("=== FAIL ===");
        $finish;
    end

    // ************************************************************************
    // helpers
    // ************************************************************************

    function automatic instr_t make_instr(input logic [reg_addr_w-1:0] src1,
                                          input logic [reg_addr_w-1:0] src2,
                                          input logic [reg_addr_w-1:0] dst);
        instr_t i;
        i = init_instr;
        i.valid = 1'b1;
        i.rden1 = 1'b1;
        i.rden2 = 1'b1;
        i.raddr1 = src1;
        i.raddr2 = src2;
        i.waddr = dst;
        i.wren = 1'b1;
        i.pc = $urandom();
        return i;
    endfunction

    function automatic result_t make_result(input logic load, input logic [reg_addr_w-1:0] dst,
                                            input logic [xlen-1:0] data);
        result_t r;
        r.valid = 1'b1;
        r.wren = 1'b1;
        r.load = load;
        r.waddr = dst;
        r.wdata = data;
        return r;
    endfunction

    task automatic idle();
        instr0 = init_instr;
        instr1 = init_instr;
        ex0 = '0;
        ex1 = '0;
        mem0 = '0;
        mem1 = '0;
    endtask

    task automatic tick();
        @(posedge clock);
        #2;
    endtask

    task automatic check(input string what, input logic [xlen-1:0] expected,
                         input logic [xlen-1:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s, %s: expected %h actual %h", test_name, what,
                     expected, actual);
            errors++;
        end
    endtask

    // the instruction part of an issued record leads the two operands.
    task automatic check_instr(input string what, input instr_t expected,
                               input issued_t actual);
        instr_t got;
        got = actual[$bits(issued_t)-1 -: $bits(instr_t)];
        if (got !== expected) begin
            $display("CHECK FAILED %s, %s: expected %h actual %h", test_name, what,
                     expected, got);
            errors++;
        end
    endtask

    task automatic wait_issue();
        int n;
        logic seen;
        seen = 1'b0;
        for (n = 0; n < 4 && !seen; n++) begin
            tick();
            seen = issued0.valid;
        end
        if (!seen) begin
            $display("timeout in %s, no instruction was issued within 4 cycles", test_name);
            errors++;
        end else if (n != 1) begin
            $display("slow issue in %s, the instruction took %0d cycles instead of one",
                     test_name, n);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_start) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s: failed", test_name);
        end
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************

    initial begin
        logic [xlen-1:0] v [5];
        instr_t s0;
        instr_t s1;
        int k;
        int asserts;
        void'($urandom(35539));
        idle();
        clear = 1'b0;
        hold = 1'b0;
        reset = 1'b0;
        repeat (3) @(posedge clock);
        #2 reset = 1'b1;

        begin_test("reset");
        tick();
        check("issued0 valid", 32'd0, 32'(issued0.valid));
        check("issued1 valid", 32'd0, 32'(issued1.valid));
        check("issue_stall", 32'd0, 32'(issue_stall));
        end_test();

        begin_test("register write and read");
        for (k = 0; k < 5; k++) begin
            v[k] = $urandom();
        end
        mem0 = make_result(1'b0, 5'd5, v[0]);
        mem1 = make_result(1'b0, 5'd6, v[1]);
        tick();
        mem0 = make_result(1'b0, 5'd7, v[2]);
        mem1 = make_result(1'b0, 5'd7, v[3]);   // mem1 must win on the same address.
        tick();
        mem0 = make_result(1'b0, 5'd0, v[4]);
        mem1 = '0;
        tick();
        mem0 = '0;
        instr0 = make_instr(5'd5, 5'd6, 5'd1);
        instr1 = make_instr(5'd0, 5'd7, 5'd2);
        wait_issue();
        check("reg 5", v[0], issued0.rdata1);
        check("reg 6", v[1], issued0.rdata2);
        check("reg 0", 32'd0, issued1.rdata1);
        check("reg 7", v[3], issued1.rdata2);
        idle();
        end_test();

        begin_test("forwarding priority");
        for (k = 0; k < 4; k++) begin
            v[k] = $urandom();
        end
        ex1 = make_result(1'b0, 5'd9, v[0]);
        ex0 = make_result(1'b0, 5'd9, v[1]);
        mem1 = make_result(1'b0, 5'd9, v[2]);
        mem0 = make_result(1'b0, 5'd9, v[3]);
        instr0 = make_instr(5'd9, 5'd9, 5'd3);
        instr1 = make_instr(5'd5, 5'd9, 5'd4);
        wait_issue();
        check("ex1 on slot 0", v[0], issued0.rdata1);
        check("ex1 on slot 1", v[0], issued1.rdata2);
        ex1 = '0;
        wait_issue();
        check("ex0", v[1], issued0.rdata1);
        ex0 = '0;
        wait_issue();
        check("mem1", v[2], issued0.rdata2);
        mem1 = '0;
        wait_issue();
        check("mem0", v[3], issued0.rdata1);
        idle();
        end_test();

        begin_test("load-use");
        ex0 = make_result(1'b1, 5'd12, $urandom());
        instr0 = make_instr(5'd1, 5'd2, 5'd3);
        instr1 = make_instr(5'd4, 5'd12, 5'd5);
        #1 check("stall", 32'd1, 32'(issue_stall));
        tick();
        check("bubble slot 0", 32'd0, 32'(issued0.valid));
        check("bubble slot 1", 32'd0, 32'(issued1.valid));
        ex0 = make_result(1'b1, 5'd0, $urandom());
        instr1 = make_instr(5'd4, 5'd0, 5'd5);
        #1 check("no stall on reg 0", 32'd0, 32'(issue_stall));
        wait_issue();
        idle();
        end_test();

        begin_test("hold");
        v[0] = $urandom();
        mem0 = make_result(1'b0, 5'd5, v[0]);
        instr0 = make_instr(5'd5, 5'd6, 5'd7);
        instr1 = make_instr(5'd7, 5'd5, 5'd8);
        s0 = instr0;
        s1 = instr1;
        wait_issue();
        mem0 = '0;
        hold = 1'b1;
        instr0 = make_instr(5'd1, 5'd2, 5'd3);
        instr1 = make_instr(5'd2, 5'd1, 5'd4);
        tick();
        tick();
        check_instr("slot 0 instruction", s0, issued0);
        check("slot 0 operand", v[0], issued0.rdata1);
        check_instr("slot 1 instruction", s1, issued1);
        check("slot 1 operand", v[0], issued1.rdata2);
        end_test();

        begin_test("clear");
        clear = 1'b1;   // hold is still high here.
        tick();
        clear = 1'b0;
        hold = 1'b0;
        idle();
        check("slot 0 valid", 32'd0, 32'(issued0.valid));
        check("slot 1 valid", 32'd0, 32'(issued1.valid));
        end_test();

        tick();
        tick();
        asserts = i_issue_top.i_chk.fail_count;
        $display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
                 tests, failed_tests, errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* issue_top.f */
issue_pkg.sv
issue_read_if.sv
register_file.sv
operand_forward.sv
load_use_detect.sv
issue_control.sv
issue_top.sv
issue_top_chk.sv
tb_issue_top.sv

/* run.sh */
#!/bin/sh
# Build and run the issue stage testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_issue_top \
    -f issue_top.f -o sim_issue_top
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_issue_top +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
